/* Makefile */
# Verilator build and run of the shared Wishbone bus testbench
# Any variable below can be set on the command line, e.g. make sim BUILD_DIR=out

TOP       ?= tb_wb_shared_bus
BUILD_DIR ?= build
VERILATOR ?= verilator
FILE_LIST ?= vlog.f
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert
# Let assertion errors reach the testbench instead of stopping at once
RUNFLAGS  ?= +verilator+error+limit+100
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	mkdir -p $(BUILD_DIR)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	$(BUILD_DIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR)

/* hdl/arb_grant_hold.sv */
`timescale 1ns/1ps

// Grant holder placed after an arbiter
// A granted requester that keeps its hold input high keeps the grant
// While the grant is held the arbiter may not move its priority
module arb_grant_hold
  import wb_arb_pkg::*;
#(
  parameter int num_masters = default_num_masters
) (
  input  logic                   clk,
  input  logic                   rst,
  // One hold request per requester, it only counts for the granted one
  input  logic [num_masters-1:0] grant_hold,
  // Priority update request from the user of this block
  input  logic                   enable_priority_update,
  // Arbiter side
  input  logic [num_masters-1:0] grant_from_arb,
  output logic                   enable_priority_update_to_arb,
  // Grant after the hold is applied
  output logic [num_masters-1:0] grant
);

  // Requester that holds the grant, all zero when nobody does
  logic [num_masters-1:0] hold;

  // A hold for a requester without the grant has no effect
  always_ff @(posedge clk) begin
    if (rst) begin
      hold <= '0;
    end else begin
      hold <= grant & grant_hold;
    end
  end

  // The held requester overrides whatever the arbiter would pick now
  assign grant = (|hold) ? hold : grant_from_arb;

  // Freeze the arbiter's priority for as long as a grant is held
  assign enable_priority_update_to_arb = enable_priority_update && !(|hold);

endmodule : arb_grant_hold

/* hdl/arb_round_robin.sv */
`timescale 1ns/1ps

// Round-robin arbiter
// The grant is combinational from the requests
// The priority pointer names the requester that is looked at first
module arb_round_robin
  import wb_arb_pkg::*;
#(
  parameter int num_masters = default_num_masters
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [num_masters-1:0] request,
  // When high, a nonzero grant moves the pointer at the next edge
  input  logic                   enable_priority_update,
  output logic [num_masters-1:0] grant
);

  // Enough bits to name any requester
  localparam int ptr_width = (num_masters > 1) ? $clog2(num_masters) : 1;

  // Requester with the highest priority in this cycle
  logic [ptr_width-1:0] pointer;

  // Index of the requester that won in this cycle
  logic [ptr_width-1:0] grant_idx;

  // Position after the winner, where priority goes on an update
  logic [ptr_width-1:0] next_pointer;

  // Scan the requesters starting at the pointer and wrapping round
  // The first one found wins, so the grant is one-hot or all zero
  always_comb begin : find_winner
    int   idx;
    logic found;
    grant     = '0;
    grant_idx = '0;
    found     = 1'b0;
    for (int i = 0; i < num_masters; i++) begin
      idx = int'(pointer) + i;
      // Wrap without a modulo so that any master count works
      if (idx >= num_masters) begin
        idx = idx - num_masters;
      end
      if (!found && request[idx]) begin
        found      = 1'b1;
        grant[idx] = 1'b1;
        grant_idx  = ptr_width'(idx);
      end
    end
  end

  // The last requester wraps back to requester 0
  always_comb begin
    if (grant_idx == ptr_width'(num_masters - 1)) begin
      next_pointer = '0;
    end else begin
      next_pointer = grant_idx + 1'b1;
    end
  end

  // The pointer moves past the winner only when updates are enabled
  // With no request there is no winner and priority stays where it is
  always_ff @(posedge clk) begin
    if (rst) begin
      pointer <= '0;
    end else if (enable_priority_update && (|grant)) begin
      pointer <= next_pointer;
    end
  end

endmodule : arb_round_robin

/* hdl/wb_arb_pkg.sv */
// Shared types for the Wishbone shared bus
// The slave is a word-addressed RAM, so the address counts data words and not bytes
package wb_arb_pkg;

  // Width of one data word on the bus
  localparam int data_width = 32;

  // Word address width, which gives a 256-word address space
  localparam int addr_width = 8;

  // One byte select per byte lane of the data word
  localparam int sel_width = data_width / 8;

  // Number of bits in one byte lane
  localparam int lane_width = data_width / sel_width;

  // Number of words that the RAM slave holds
  localparam int ram_depth = 2 ** addr_width;

  // Master count used when the top level sets no other value
  localparam int default_num_masters = 4;

  // One bus data word
  typedef logic [data_width-1:0] data_t;

  // One word address
  typedef logic [addr_width-1:0] addr_t;

  // Byte selects, bit n enables byte lane n of data_t
  typedef logic [sel_width-1:0] sel_t;

endpackage : wb_arb_pkg

/* hdl/wb_bus_mux.sv */
`timescale 1ns/1ps

// Wishbone classic bus mux between several masters and one slave
// The grant is one-hot or zero and selects which master reaches the slave
module wb_bus_mux
  import wb_arb_pkg::*;
#(
  parameter int num_masters = default_num_masters
) (
  input  logic [num_masters-1:0]        grant,
  // Master side, one entry per master
  input  logic [num_masters-1:0]        m_cyc,
  input  logic [num_masters-1:0]        m_stb,
  input  logic [num_masters-1:0]        m_we,
  input  addr_t [num_masters-1:0]       m_adr,
  input  data_t [num_masters-1:0]       m_dat_w,
  input  sel_t [num_masters-1:0]        m_sel,
  output logic [num_masters-1:0]        m_ack,
  // Read data is shared and only valid for the master that sees ack
  output data_t                         m_dat_r,
  // Slave side
  output logic                          s_cyc,
  output logic                          s_stb,
  output logic                          s_we,
  output addr_t                         s_adr,
  output data_t                         s_dat_w,
  output sel_t                          s_sel,
  input  logic                          s_ack,
  input  data_t                         s_dat_r
);

  // A master without the grant never reaches the slave
  // It keeps waiting with cyc and stb high and gets no ack
  assign s_cyc = |(grant & m_cyc);
  assign s_stb = |(grant & m_stb);

  // AND-OR mux, which relies on the grant being one-hot
  // With no grant all slave fields read as zero
  always_comb begin
    s_we    = 1'b0;
    s_adr   = '0;
    s_dat_w = '0;
    s_sel   = '0;
    for (int i = 0; i < num_masters; i++) begin
      s_we    = s_we | (m_we[i] & grant[i]);
      s_adr   = s_adr | (m_adr[i] & {addr_width{grant[i]}});
      s_dat_w = s_dat_w | (m_dat_w[i] & {data_width{grant[i]}});
      s_sel   = s_sel | (m_sel[i] & {sel_width{grant[i]}});
    end
  end

  // The slave's ack goes back to the granted master only
  // The grant cannot move during a beat, because the owner holds cyc until ack
  assign m_ack = grant & {num_masters{s_ack}};

  // Read data goes to every master, ack tells the owner when to take it
  assign m_dat_r = s_dat_r;

endmodule : wb_bus_mux

/* hdl/wb_ram.sv */
`timescale 1ns/1ps

// Wishbone classic RAM slave with one wait state per beat
// Addresses count words, and writes honour the byte selects
module wb_ram
  import wb_arb_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  cyc,
  input  logic  stb,
  input  logic  we,
  input  addr_t adr,
  input  data_t dat_w,
  input  sel_t  sel,
  output logic  ack,
  output data_t dat_r
);

  // Word storage
  data_t mem [ram_depth];

  // High in the first cycle of a beat, before ack has been given
  logic beat_start;

  // Ack being high marks the second cycle of a beat
  // Blocking on it keeps one beat from being acked twice
  assign beat_start = cyc && stb && !ack;

  // One wait state, ack comes in the cycle after the beat starts
  // and drops again one cycle later
  always_ff @(posedge clk) begin
    if (rst) begin
      ack <= 1'b0;
    end else begin
      ack <= beat_start;
    end
  end

  // Write only the byte lanes whose select bit is set
  always_ff @(posedge clk) begin
    if (beat_start && we) begin
      for (int b = 0; b < sel_width; b++) begin
        if (sel[b]) begin
          mem[adr][b*lane_width +: lane_width] <= dat_w[b*lane_width +: lane_width];
        end
      end
    end
  end

  // Read data is captured at the start of the beat so it is valid with ack
  // On a write beat it shows the old word, which no master looks at
  always_ff @(posedge clk) begin
    if (beat_start) begin
      dat_r <= mem[adr];
    end
  end

endmodule : wb_ram

/* hdl/wb_shared_bus.sv */
`timescale 1ns/1ps

// Shared Wishbone classic bus with a round-robin arbiter and one RAM slave
// A master keeps the bus for as long as it keeps cyc high,
// so a block of several beats under one cyc is never split
module wb_shared_bus
  import wb_arb_pkg::*;
#(
  parameter int num_masters = default_num_masters
) (
  input  logic                          clk,
  input  logic                          rst,
  // Master ports, one entry per master
  input  logic [num_masters-1:0]        m_cyc,
  input  logic [num_masters-1:0]        m_stb,
  input  logic [num_masters-1:0]        m_we,
  input  addr_t [num_masters-1:0]       m_adr,
  input  data_t [num_masters-1:0]       m_dat_w,
  input  sel_t [num_masters-1:0]        m_sel,
  output logic [num_masters-1:0]        m_ack,
  output data_t                         m_dat_r,
  // Current owner of the bus
  output logic [num_masters-1:0]        grant
);

  // Arbiter to grant holder
  logic [num_masters-1:0] grant_from_arb;
  logic                   enable_priority_update_to_arb;

  // Mux to RAM
  logic  s_cyc;
  logic  s_stb;
  logic  s_we;
  addr_t s_adr;
  data_t s_dat_w;
  sel_t  s_sel;
  logic  s_ack;
  data_t s_dat_r;

  // Every master with cyc high asks for the bus
  arb_round_robin #(
    .num_masters(num_masters)
  ) u_arb (
    .clk                   (clk),
    .rst                   (rst),
    .request               (m_cyc),
    .enable_priority_update(enable_priority_update_to_arb),
    .grant                 (grant_from_arb)
  );

  // Priority always moves on a new grant, the hold is what freezes it
  arb_grant_hold #(
    .num_masters(num_masters)
  ) u_grant_hold (
    .clk                          (clk),
    .rst                          (rst),
    .grant_hold                   (m_cyc),
    .enable_priority_update       (1'b1),
    .grant_from_arb               (grant_from_arb),
    .enable_priority_update_to_arb(enable_priority_update_to_arb),
    .grant                        (grant)
  );

  wb_bus_mux #(
    .num_masters(num_masters)
  ) u_mux (
    .grant  (grant),
    .m_cyc  (m_cyc),
    .m_stb  (m_stb),
    .m_we   (m_we),
    .m_adr  (m_adr),
    .m_dat_w(m_dat_w),
    .m_sel  (m_sel),
    .m_ack  (m_ack),
    .m_dat_r(m_dat_r),
    .s_cyc  (s_cyc),
    .s_stb  (s_stb),
    .s_we   (s_we),
    .s_adr  (s_adr),
    .s_dat_w(s_dat_w),
    .s_sel  (s_sel),
    .s_ack  (s_ack),
    .s_dat_r(s_dat_r)
  );

  wb_ram u_ram (
    .clk  (clk),
    .rst  (rst),
    .cyc  (s_cyc),
    .stb  (s_stb),
    .we   (s_we),
    .adr  (s_adr),
    .dat_w(s_dat_w),
    .sel  (s_sel),
    .ack  (s_ack),
    .dat_r(s_dat_r)
  );

endmodule : wb_shared_bus

/* tests/tb_wb_shared_bus.sv */
`timescale 1ns/1ps

// Testbench for the shared Wishbone bus with four masters
// Each table entry is one transfer of one or more beats from one master
// Entries flagged together start in the same cycle as the entry before them
module tb_wb_shared_bus
  import wb_arb_pkg::*;
();

  localparam int num_masters    = 4;
  localparam int timeout_cycles = 50;
  localparam int random_entries = 40;

  typedef logic [num_masters-1:0] grant_t;

  // Beat n of a transfer uses addr + n and data + n
  typedef struct {
    int    master;
    int    beats;
    logic  we;
    addr_t addr;
    data_t data;
    sel_t  sel;
    logic  together;
  } entry_t;

  logic                    clk;
  logic                    rst;
  grant_t                  m_cyc;
  grant_t                  m_stb;
  grant_t                  m_we;
  addr_t [num_masters-1:0] m_adr;
  data_t [num_masters-1:0] m_dat_w;
  sel_t [num_masters-1:0]  m_sel;
  grant_t                  m_ack;
  data_t                   m_dat_r;
  grant_t                  grant;

  entry_t      stim_q[$];
  // Expected RAM contents are updated in bus order as write acks arrive
  data_t       model_mem [ram_depth];
  logic [31:0] lfsr_state;
  // Per-master progress through the current entry
  int          cur_entry [num_masters];
  int          beat_num [num_masters];
  grant_t      busy;
  grant_t      acked;
  // Expected bus owner or -1 while the bus is free
  int          owner;
  // Expected round-robin priority names the master that is looked at first
  int          rr_ptr;

  wb_shared_bus #(
    .num_masters(num_masters)
  ) DUT (
    .clk    (clk),
    .rst    (rst),
    .m_cyc  (m_cyc),
    .m_stb  (m_stb),
    .m_we   (m_we),
    .m_adr  (m_adr),
    .m_dat_w(m_dat_w),
    .m_sel  (m_sel),
    .m_ack  (m_ack),
    .m_dat_r(m_dat_r),
    .grant  (grant)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_data(string name, data_t expected, data_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("FAIL at %0t ns: %s expected %h actual %h",
                               $time, name, expected, actual));
    end
  endtask

  task automatic check_grant(string name, grant_t expected, grant_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("FAIL at %0t ns: %s expected %b actual %b",
                               $time, name, expected, actual));
    end
  endtask

  // Galois LFSR for x^32 + x^22 + x^2 + x + 1 that steps once for each bit taken
  function automatic logic [31:0] rand_bits(int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsr_state[0]};
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return value;
  endfunction

  // Byte lanes with sel set take the new word and the rest keep the old one
  function automatic data_t merge_bytes(data_t old_word, data_t new_word, sel_t sel);
    data_t result;
    result = old_word;
    for (int b = 0; b < sel_width; b++) begin
      if (sel[b]) begin
        result[b*lane_width +: lane_width] = new_word[b*lane_width +: lane_width];
      end
    end
    return result;
  endfunction

  // First busy master at or after the priority with wrap round
  function automatic int pick_next();
    int idx;
    for (int i = 0; i < num_masters; i++) begin
      idx = (rr_ptr + i) % num_masters;
      if (busy[idx]) begin
        return idx;
      end
    end
    return -1;
  endfunction

  function automatic void add_entry(int master, int beats, logic we, addr_t addr,
                                    data_t data, sel_t sel, logic together);
    entry_t e;
    e = '{master, beats, we, addr, data, sel, together};
    stim_q.push_back(e);
  endfunction

  task automatic build_table();
    logic [31:0] bits;
    logic        together;
    grant_t      group_mask;
    // All four start right after reset and are served in order 0 to 3
    add_entry(0, 1, 1'b1, 8'h00, 32'h1000_0000, 4'hf, 1'b0);
    add_entry(1, 1, 1'b1, 8'h01, 32'h1100_0001, 4'hf, 1'b1);
    add_entry(2, 1, 1'b1, 8'h02, 32'h1200_0002, 4'hf, 1'b1);
    add_entry(3, 1, 1'b1, 8'h03, 32'h1300_0003, 4'hf, 1'b1);
    // Single writes and reads from one master
    add_entry(0, 1, 1'b1, 8'h10, 32'hdead_beef, 4'hf, 1'b0);
    add_entry(0, 1, 1'b1, 8'h11, 32'h0123_4567, 4'hf, 1'b0);
    add_entry(0, 1, 1'b0, 8'h10, 32'h0, 4'hf, 1'b0);
    add_entry(0, 1, 1'b0, 8'h11, 32'h0, 4'hf, 1'b0);
    // Byte selects merge into the stored word
    add_entry(1, 1, 1'b1, 8'h20, 32'h1122_3344, 4'hf, 1'b0);
    add_entry(1, 1, 1'b1, 8'h20, 32'haabb_ccdd, 4'b0101, 1'b0);
    add_entry(1, 1, 1'b0, 8'h20, 32'h0, 4'hf, 1'b0);
    add_entry(2, 1, 1'b1, 8'h20, 32'h5566_7788, 4'b1000, 1'b0);
    add_entry(3, 1, 1'b0, 8'h20, 32'h0, 4'hf, 1'b0);
    // Master 0 runs 4-beat blocks while others wait for the bus
    add_entry(0, 4, 1'b1, 8'h30, 32'hb10c_0000, 4'hf, 1'b0);
    add_entry(1, 1, 1'b0, 8'h10, 32'h0, 4'hf, 1'b1);
    add_entry(3, 1, 1'b1, 8'h38, 32'h3838_3838, 4'hf, 1'b1);
    add_entry(0, 4, 1'b0, 8'h30, 32'h0, 4'hf, 1'b0);
    add_entry(2, 1, 1'b0, 8'h31, 32'h0, 4'hf, 1'b1);
    // Master 1 alone and then a full round that starts at master 2
    add_entry(1, 1, 1'b0, 8'h01, 32'h0, 4'hf, 1'b0);
    add_entry(0, 1, 1'b0, 8'h00, 32'h0, 4'hf, 1'b0);
    add_entry(1, 1, 1'b0, 8'h01, 32'h0, 4'hf, 1'b1);
    add_entry(2, 1, 1'b0, 8'h02, 32'h0, 4'hf, 1'b1);
    add_entry(3, 1, 1'b0, 8'h03, 32'h0, 4'hf, 1'b1);
    // Fill the window 0x40 to 0x53 that the random traffic uses
    add_entry(3, 20, 1'b1, 8'h40, 32'h4000_0000, 4'hf, 1'b0);
    // The fill runs alone so that every word is defined before random reads
    group_mask = '1;
    for (int i = 0; i < random_entries; i++) begin
      int    master;
      int    beats;
      logic  we;
      addr_t addr;
      data_t data;
      sel_t  sel;
      master = int'(rand_bits(2));
      beats  = 1 + int'(rand_bits(2));
      bits   = rand_bits(1);
      we     = bits[0];
      bits   = rand_bits(4);
      addr   = 8'h40 + addr_t'(bits);
      data   = rand_bits(32);
      bits   = rand_bits(4);
      sel    = sel_t'(bits);
      bits   = rand_bits(1);
      // A master can join the running group only once
      together = bits[0] && !group_mask[master];
      if (!together) begin
        group_mask = '0;
      end
      group_mask[master] = 1'b1;
      add_entry(master, beats, we, addr, data, sel, together);
    end
  endtask

  task automatic drive_beat(int m);
    int k;
    k = cur_entry[m];
    m_cyc[m]   = 1'b1;
    m_stb[m]   = 1'b1;
    m_we[m]    = stim_q[k].we;
    m_adr[m]   = stim_q[k].addr + addr_t'(beat_num[m]);
    m_dat_w[m] = stim_q[k].data + data_t'(beat_num[m]);
    m_sel[m]   = stim_q[k].sel;
  endtask

  task automatic release_master(int m);
    m_cyc[m] = 1'b0;
    m_stb[m] = 1'b0;
    busy[m]  = 1'b0;
    if (owner == m) begin
      owner = -1;
    end
  endtask

  // Called at the falling edge of a cycle in which master m sees ack
  task automatic handle_ack(int m);
    int     k;
    addr_t  adr;
    grant_t expected;
    k = cur_entry[m];
    // A free bus goes to the next busy master in round-robin order
    if (owner < 0) begin
      owner  = pick_next();
      rr_ptr = (owner + 1) % num_masters;
    end
    expected        = '0;
    expected[owner] = 1'b1;
    check_grant("grant", expected, grant);
    check_grant("m_ack", expected, m_ack);
    adr = stim_q[k].addr + addr_t'(beat_num[m]);
    if (stim_q[k].we) begin
      model_mem[adr] = merge_bytes(model_mem[adr], stim_q[k].data + data_t'(beat_num[m]),
                                   stim_q[k].sel);
    end else begin
      check_data("m_dat_r", model_mem[adr], m_dat_r);
    end
    beat_num[m]++;
    acked[m] = 1'b1;
  endtask

  // Starts entries first to last together and runs until all have finished
  task automatic run_group(int first, int last);
    int m;
    int idle;
    for (int k = first; k <= last; k++) begin
      m            = stim_q[k].master;
      cur_entry[m] = k;
      beat_num[m]  = 0;
      busy[m]      = 1'b1;
      drive_beat(m);
    end
    idle = 0;
    while (busy != '0) begin
      @(negedge clk);
      acked = '0;
      for (int i = 0; i < num_masters; i++) begin
        if (m_ack[i] && !busy[i]) begin
          report_failure($sformatf("Master %0d got an ack without a transfer", i));
        end else if (m_ack[i]) begin
          handle_ack(i);
        end
      end
      if (acked != '0) begin
        idle = 0;
      end else begin
        idle++;
        if (idle >= timeout_cycles) begin
          report_failure($sformatf("No ack arrived within %0d cycles", timeout_cycles));
        end
      end
      @(posedge clk);
      #5;
      for (int i = 0; i < num_masters; i++) begin
        if (acked[i] && beat_num[i] == stim_q[cur_entry[i]].beats) begin
          release_master(i);
        end else if (acked[i]) begin
          drive_beat(i);
        end
      end
    end
  endtask

  // Watch the bound protocol checker
  always @(negedge clk) begin
    if (DUT.u_checker.error_count != 0) begin
      report_failure("A bus protocol assertion failed");
    end
  end

  initial begin
    int first;
    int last;
    rst        = 1'b1;
    m_cyc      = '0;
    m_stb      = '0;
    m_we       = '0;
    m_adr      = '0;
    m_dat_w    = '0;
    m_sel      = '0;
    busy       = '0;
    acked      = '0;
    owner      = -1;
    rr_ptr     = 0;
    lfsr_state = 32'hc877;
    build_table();
    repeat (2) @(posedge clk);
    #5;
    rst   = 1'b0;
    first = 0;
    while (first < stim_q.size()) begin
      last = first;
      while (last + 1 < stim_q.size() && stim_q[last + 1].together) begin
        last++;
      end
      run_group(first, last);
      // One idle cycle between groups keeps cyc low between owners
      @(posedge clk);
      #5;
      first = last + 1;
    end
    if (DUT.u_checker.error_count == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      report_failure("A bus protocol assertion failed");
    end
  end

endmodule : tb_wb_shared_bus

/* tests/wb_shared_bus_checker.sv */
`timescale 1ns/1ps

// Protocol assertions for the shared Wishbone bus
// Only ports of the top level are observed, no internal signal is probed
module wb_shared_bus_checker
  import wb_arb_pkg::*;
#(
  parameter int num_masters = default_num_masters
) (
  input logic                   clk,
  input logic                   rst,
  input logic [num_masters-1:0] m_cyc,
  input logic [num_masters-1:0] m_ack,
  input logic [num_masters-1:0] grant
);

  // Number of assertion failures seen so far
  int unsigned error_count = 0;

  // The bus has at most one owner
  grant_one_hot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else begin
      error_count++;
      $error("grant names more than one master");
    end

  // The slave answers one master at a time
  ack_one_hot: assert property (@(posedge clk) disable iff (rst) $onehot0(m_ack))
    else begin
      error_count++;
      $error("more than one m_ack bit is high");
    end

  // No master sees ack unless it owns the bus
  ack_to_owner: assert property (@(posedge clk) disable iff (rst) (m_ack & ~grant) == '0)
    else begin
      error_count++;
      $error("m_ack is high for a master without the grant");
    end

  // The hold register loads grant masked by cyc, so an owner with cyc
  // high must still own the bus in the next cycle
  grant_held: assert property (@(posedge clk) disable iff (rst)
    (|(grant & m_cyc)) |=> $stable(grant))
    else begin
      error_count++;
      $error("grant moved while its owner still held cyc");
    end

endmodule : wb_shared_bus_checker

bind wb_shared_bus wb_shared_bus_checker #(
  .num_masters(num_masters)
) u_checker (
  .clk  (clk),
  .rst  (rst),
  .m_cyc(m_cyc),
  .m_ack(m_ack),
  .grant(grant)
);

/* vlog.f */
hdl/wb_arb_pkg.sv
hdl/arb_round_robin.sv
hdl/arb_grant_hold.sv
hdl/wb_bus_mux.sv
hdl/wb_ram.sv
hdl/wb_shared_bus.sv
tests/wb_shared_bus_checker.sv
tests/tb_wb_shared_bus.sv
